// ==== filter_pkg.sv ====
package filter_pkg;

    // audio samples and coefficients are both 16-bit two's complement.
    typedef logic signed [15:0] sample_t;    // signed audio sample.
    typedef logic signed [15:0] coef_t;      // signed Q2.14 coefficient.
    typedef logic signed [39:0] acc_t;       // holds five 32-bit products with room to spare.
    typedef logic [3:0]         coef_addr_t; // word address into the coefficient memory.

    localparam int COEF_FRAC         = 14;  // fractional bits of a Q2.14 coefficient.
    localparam int COEF_DEPTH        = 16;  // words in the coefficient memory.
    localparam int SECTION_STRIDE    = 8;   // address distance between two coefficient sets.
    localparam int COEFS_PER_SECTION = 5;   // b0, b1, b2, a1, a2 at offsets 0 to 4.

    localparam int SAMPLE_MAX = 32767;   // upper saturation limit.
    localparam int SAMPLE_MIN = -32768;  // lower saturation limit.

    // requester numbers used by the arbiter, in round-robin order.
    localparam logic [1:0] REQ_HOST = 2'd0;
    localparam logic [1:0] REQ_SEC0 = 2'd1;
    localparam logic [1:0] REQ_SEC1 = 2'd2;
    localparam int         NUM_REQ  = 3;

    // coefficient loader inside each biquad section.
    typedef enum logic [2:0] {
        LDR_IDLE,          // waiting for a rising edge on reload.
        LDR_REQUEST,       // raise req for the next word.
        LDR_WAIT_ACK,      // req is up, waiting for the arbiter.
        LDR_RELEASE,       // req is down, waiting for ack to fall.
        LDR_SWAP_PENDING   // shadow set complete, waiting for an empty pipeline.
    } loader_state_t;

    // coefficient memory arbiter.
    typedef enum logic [1:0] {
        ARB_IDLE,     // no access in progress.
        ARB_ACCESS,   // memory enabled, then one cycle for the read data.
        ARB_ACKED,    // ack is up, waiting for the winner to drop req.
        ARB_RELEASE   // ack is down, one cycle before the next grant.
    } arb_state_t;

endpackage

// ==== coef_bank.sv ====
`timescale 1ns/10ps

// single-port coefficient memory.
// Writes take effect at the clock edge where en and we are both high.
// A read with en high and we low returns the word one cycle later on rdata.
module coef_bank (
    input  logic                   clk,
    input  logic                   en,     // access strobe from the arbiter.
    input  logic                   we,     // high for a host write, low for a loader read.
    input  filter_pkg::coef_addr_t addr,   // word address.
    input  filter_pkg::coef_t      wdata,  // write data from the host.
    output filter_pkg::coef_t      rdata   // read data, one cycle after the read strobe.
);

    filter_pkg::coef_t mem [filter_pkg::COEF_DEPTH]; // one word per coefficient slot.

    // write port.
    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    // read port. rdata keeps its value until the next read,
    // so the arbiter may sample it one cycle after the strobe.
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== coef_arbiter.sv ====
`timescale 1ns/10ps

// round-robin arbiter between the host writer and the two section loaders.
// Each peer uses a four-phase req/ack handshake. One access is served at a time,
// and after it completes the next grant goes to the peer after the last one served.
module coef_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   host_req,    // host write request.
    input  filter_pkg::coef_addr_t host_addr,
    input  filter_pkg::coef_t      host_wdata,
    output logic                   host_ack,
    input  logic [1:0]             ldr_req,     // one read request per section loader.
    input  filter_pkg::coef_addr_t ldr_addr0,
    input  filter_pkg::coef_addr_t ldr_addr1,
    output logic [1:0]             ldr_ack,
    output filter_pkg::coef_t      ldr_rdata,   // held stable while ack is high.
    output logic                   mem_en,
    output logic                   mem_we,
    output filter_pkg::coef_addr_t mem_addr,
    output filter_pkg::coef_t      mem_wdata,
    input  filter_pkg::coef_t      mem_rdata
);

    filter_pkg::arb_state_t state;
    logic [2:0] req_vec;     // bit 0 host, bit 1 section 0, bit 2 section 1.
    logic [1:0] grant_q;     // requester being served.
    logic [1:0] last_q;      // requester served most recently.
    logic       ack_q;       // ack for whoever holds the grant.
    logic [1:0] pick;        // next winner in round-robin order.
    logic       pick_valid;  // high when any peer is requesting.

    assign req_vec = {ldr_req, host_req};

    // search the peers starting at the one after last_q. The loop runs backwards
    // so the nearest requester in round-robin order is written last and wins.
    always_comb begin
        int unsigned cand;
        pick       = last_q;
        pick_valid = 1'b0;
        for (int i = filter_pkg::NUM_REQ; i >= 1; i--) begin
            cand = (int'(last_q) + i) % filter_pkg::NUM_REQ;
            if (req_vec[cand]) begin
                pick       = 2'(cand);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= filter_pkg::ARB_IDLE;
            grant_q <= filter_pkg::REQ_HOST;
            last_q  <= filter_pkg::REQ_SEC1; // so the host comes first after reset.
            ack_q   <= 1'b0;
            mem_en  <= 1'b0;
        end else begin
            case (state)
                filter_pkg::ARB_IDLE: begin
                    if (pick_valid) begin
                        grant_q <= pick;
                        last_q  <= pick;   // the round-robin order moves on at grant.
                        mem_en  <= 1'b1;
                        state   <= filter_pkg::ARB_ACCESS;
                    end
                end
                filter_pkg::ARB_ACCESS: begin
                    if (mem_en) begin
                        mem_en <= 1'b0;    // memory takes the access at this edge.
                    end else begin
                        ack_q <= 1'b1;     // read data is on mem_rdata by now.
                        state <= filter_pkg::ARB_ACKED;
                    end
                end
                filter_pkg::ARB_ACKED: begin
                    if (!req_vec[grant_q]) begin
                        ack_q <= 1'b0;     // phase 4 of the handshake.
                        state <= filter_pkg::ARB_RELEASE;
                    end
                end
                default: begin
                    state <= filter_pkg::ARB_IDLE; // one quiet cycle with ack low.
                end
            endcase
        end
    end

    // address, data and direction are latched once at grant and held through the access.
    always_ff @(posedge clk) begin
        if (state == filter_pkg::ARB_IDLE && pick_valid) begin
            mem_we    <= (pick == filter_pkg::REQ_HOST);
            mem_wdata <= host_wdata;
            case (pick)
                filter_pkg::REQ_HOST: mem_addr <= host_addr;
                filter_pkg::REQ_SEC0: mem_addr <= ldr_addr0;
                default:              mem_addr <= ldr_addr1;
            endcase
        end
    end

    // capture the read word in the same edge that raises ack.
    always_ff @(posedge clk) begin
        if (state == filter_pkg::ARB_ACCESS && !mem_en) begin
            ldr_rdata <= mem_rdata;
        end
    end

    // only the winner sees ack.
    assign host_ack   = ack_q && (grant_q == filter_pkg::REQ_HOST);
    assign ldr_ack[0] = ack_q && (grant_q == filter_pkg::REQ_SEC0);
    assign ldr_ack[1] = ack_q && (grant_q == filter_pkg::REQ_SEC1);

endmodule

// ==== biquad_section.sv ====
`timescale 1ns/10ps

// one direct-form-I biquad section.
// y[n] = b0*x[n] + b1*x[n-1] + b2*x[n-2] - a1*y[n-1] - a2*y[n-2], coefficients in Q2.14.
// The first pipeline stage registers the five products, the second registers the
// truncated and saturated sum. A loader fetches a new coefficient set into a shadow
// copy and swaps it in only while no sample is in the pipeline.
module biquad_section #(
    parameter int SECTION_BASE = 0   // address of b0 for this section.
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   reload,     // a rising edge starts a coefficient fetch.
    output logic                   busy,       // high until the new set is active.
    output logic                   ldr_req,
    output filter_pkg::coef_addr_t ldr_addr,
    input  logic                   ldr_ack,
    input  filter_pkg::coef_t      ldr_rdata,
    input  filter_pkg::sample_t    in,
    input  logic                   in_valid,
    output filter_pkg::sample_t    out,
    output logic                   out_valid   // single-cycle pulse, 2 cycles after in_valid.
);

    filter_pkg::loader_state_t state;
    logic       reload_q;   // last value of reload, for edge detection.
    logic       reload_rise;
    logic [2:0] idx;        // coefficient being fetched, 0 to 4.
    logic       pipe_empty; // no sample in either stage.

    // index 0 b0, 1 b1, 2 b2, 3 a1, 4 a2 in both sets.
    filter_pkg::coef_t shadow [filter_pkg::COEFS_PER_SECTION];
    filter_pkg::coef_t active [filter_pkg::COEFS_PER_SECTION];

    filter_pkg::sample_t x1, x2;   // x[n-1] and x[n-2].
    filter_pkg::sample_t y1, y2;   // y[n-1] and y[n-2].
    logic                valid_s1; // stage 1 holds a sample.

    filter_pkg::acc_t p_b0, p_b1, p_b2, p_a1, p_a2; // stage 1 products.
    filter_pkg::acc_t sum;
    filter_pkg::acc_t shifted;
    filter_pkg::sample_t sat;

    assign reload_rise = reload && !reload_q;
    assign pipe_empty  = !in_valid && !valid_s1 && !out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            reload_q <= 1'b0;
        end else begin
            reload_q <= reload;
        end
    end

    // coefficient loader. Every word gets a full four-phase handshake.
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= filter_pkg::LDR_IDLE;
            busy    <= 1'b0;
            ldr_req <= 1'b0;
            idx     <= '0;
            for (int i = 0; i < filter_pkg::COEFS_PER_SECTION; i++) begin
                active[i] <= '0;   // the filter outputs zero until the first reload.
            end
        end else begin
            case (state)
                filter_pkg::LDR_IDLE: begin
                    if (reload_rise) begin
                        busy  <= 1'b1;
                        idx   <= '0;
                        state <= filter_pkg::LDR_REQUEST;
                    end
                end
                filter_pkg::LDR_REQUEST: begin
                    ldr_req <= 1'b1;   // address is already stable in ldr_addr.
                    state   <= filter_pkg::LDR_WAIT_ACK;
                end
                filter_pkg::LDR_WAIT_ACK: begin
                    if (ldr_ack) begin
                        shadow[idx] <= ldr_rdata;  // data is valid while ack is high.
                        ldr_req     <= 1'b0;
                        state       <= filter_pkg::LDR_RELEASE;
                    end
                end
                filter_pkg::LDR_RELEASE: begin
                    // a new req must wait for ack to fall.
                    if (!ldr_ack) begin
                        if (idx == 3'(filter_pkg::COEFS_PER_SECTION - 1)) begin
                            state <= filter_pkg::LDR_SWAP_PENDING;
                        end else begin
                            idx   <= idx + 3'd1;
                            state <= filter_pkg::LDR_REQUEST;
                        end
                    end
                end
                default: begin
                    // swap only between samples so no sample sees a mixed set.
                    if (pipe_empty) begin
                        active <= shadow;
                        busy   <= 1'b0;
                        state  <= filter_pkg::LDR_IDLE;
                    end
                end
            endcase
        end
    end

    // the word address follows idx, and it is settled before req goes up.
    always_ff @(posedge clk) begin
        ldr_addr <= filter_pkg::coef_addr_t'(SECTION_BASE + int'(idx));
    end

    // stage 1 products. Operands are widened to acc_t before the multiply.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            p_b0 <= active[0] * in;
            p_b1 <= active[1] * x1;
            p_b2 <= active[2] * x2;
            p_a1 <= active[3] * y1;  // feedback uses the section's own last outputs.
            p_a2 <= active[4] * y2;
        end
    end

    // stage 2 arithmetic. Truncate the Q2.14 scaling, then clamp to 16 bits.
    always_comb begin
        sum     = p_b0 + p_b1 + p_b2 - p_a1 - p_a2;
        shifted = sum >>> filter_pkg::COEF_FRAC;   // arithmetic shift keeps the sign.
        if (shifted > filter_pkg::acc_t'(filter_pkg::SAMPLE_MAX)) begin
            sat = filter_pkg::sample_t'(filter_pkg::SAMPLE_MAX);
        end else if (shifted < filter_pkg::acc_t'(filter_pkg::SAMPLE_MIN)) begin
            sat = filter_pkg::sample_t'(filter_pkg::SAMPLE_MIN);
        end else begin
            sat = shifted[15:0];
        end
    end

    // valid chain and history. History moves only when a sample passes.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
            x1        <= '0;
            x2        <= '0;
            y1        <= '0;
            y2        <= '0;
        end else begin
            valid_s1  <= in_valid;
            out_valid <= valid_s1;
            if (in_valid) begin
                x1 <= in;
                x2 <= x1;
            end
            if (valid_s1) begin
                y1 <= sat;  // y1 doubles as the stage 2 output register.
                y2 <= y1;
            end
        end
    end

    assign out = y1;

endmodule

// ==== biquad_cascade.sv ====
`timescale 1ns/10ps

// two biquad sections in series with a shared coefficient memory.
// The host and both section loaders reach the memory through one arbiter.
module biquad_cascade (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   host_req,     // host coefficient write.
    input  filter_pkg::coef_addr_t host_addr,
    input  filter_pkg::coef_t      host_wdata,
    output logic                   host_ack,
    input  logic                   reload,       // starts a reload in both sections.
    output logic                   busy,         // high while either section reloads.
    input  filter_pkg::sample_t    sample_in,
    input  logic                   sample_valid,
    output filter_pkg::sample_t    sample_out,
    output logic                   sample_out_valid  // 4 cycles after sample_valid.
);

    logic [1:0]             ldr_req;
    logic [1:0]             ldr_ack;
    filter_pkg::coef_addr_t ldr_addr0, ldr_addr1;
    filter_pkg::coef_t      ldr_rdata;   // shared, only the acked loader samples it.
    logic [1:0]             sec_busy;
    filter_pkg::sample_t    mid;         // section 0 output into section 1.
    logic                   mid_valid;
    logic                   mem_en, mem_we;
    filter_pkg::coef_addr_t mem_addr;
    filter_pkg::coef_t      mem_wdata, mem_rdata;

    assign busy = |sec_busy;

    biquad_section #(
        .SECTION_BASE (0)
    ) u_section0 (
        .clk       (clk),
        .reset     (reset),
        .reload    (reload),
        .busy      (sec_busy[0]),
        .ldr_req   (ldr_req[0]),
        .ldr_addr  (ldr_addr0),
        .ldr_ack   (ldr_ack[0]),
        .ldr_rdata (ldr_rdata),
        .in        (sample_in),
        .in_valid  (sample_valid),
        .out       (mid),
        .out_valid (mid_valid)
    );

    biquad_section #(
        .SECTION_BASE (filter_pkg::SECTION_STRIDE)  // second set sits one stride up.
    ) u_section1 (
        .clk       (clk),
        .reset     (reset),
        .reload    (reload),
        .busy      (sec_busy[1]),
        .ldr_req   (ldr_req[1]),
        .ldr_addr  (ldr_addr1),
        .ldr_ack   (ldr_ack[1]),
        .ldr_rdata (ldr_rdata),
        .in        (mid),
        .in_valid  (mid_valid),
        .out       (sample_out),
        .out_valid (sample_out_valid)
    );

    coef_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .ldr_req    (ldr_req),
        .ldr_addr0  (ldr_addr0),
        .ldr_addr1  (ldr_addr1),
        .ldr_ack    (ldr_ack),
        .ldr_rdata  (ldr_rdata),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    coef_bank u_bank (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// ==== tb_biquad_cascade.sv ====
`timescale 1ns/10ps

module tb_biquad_cascade;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   host_req;
    filter_pkg::coef_addr_t host_addr;
    filter_pkg::coef_t      host_wdata;
    logic                   host_ack;
    logic                   reload;
    logic                   busy;
    filter_pkg::sample_t    sample_in;
    logic                   sample_valid;
    filter_pkg::sample_t    sample_out;
    logic                   sample_out_valid;

    int          errors;                   // every failed check adds one.
    logic [31:0] lcg_state;                // state of the pseudo-random generator.
    filter_pkg::coef_t   mem_model [16];   // what the host has written so far.
    filter_pkg::coef_t   act [2][5];       // active set per section in the model.
    filter_pkg::sample_t hx1 [2], hx2 [2]; // model input history per section.
    filter_pkg::sample_t hy1 [2], hy2 [2]; // model output history per section.

    always #20 clk = ~clk;  // 40 ns period.

    biquad_cascade u_biquad_cascade (.*);

    // numerical recipes constants give the full 32-bit period.
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // runs one sample through both modeled sections and advances their history.
    function automatic filter_pkg::sample_t model_step(input filter_pkg::sample_t x);
        longint acc;
        filter_pkg::sample_t s;
        s = x;
        for (int k = 0; k < 2; k++) begin
            acc = longint'(act[k][0]) * s + longint'(act[k][1]) * hx1[k]
                + longint'(act[k][2]) * hx2[k] - longint'(act[k][3]) * hy1[k]
                - longint'(act[k][4]) * hy2[k];
            acc = acc >>> filter_pkg::COEF_FRAC;  // truncation toward minus infinity.
            hx2[k] = hx1[k];
            hx1[k] = s;
            hy2[k] = hy1[k];
            if (acc > 32767) begin
                hy1[k] = 32767;
            end else if (acc < -32768) begin
                hy1[k] = -32768;
            end else begin
                hy1[k] = acc[15:0];
            end
            s = hy1[k];  // this section feeds the next one.
        end
        return s;
    endfunction

    task automatic host_write(input filter_pkg::coef_addr_t addr, input filter_pkg::coef_t data);
        int n;
        @(negedge clk);
        host_req   = 1'b1;  // address and data stay put until ack.
        host_addr  = addr;
        host_wdata = data;
        n = 0;
        while (!host_ack && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!host_ack) begin
            $display("host write to address %0d was never acknowledged", addr);
            errors++;
        end
        host_req = 1'b0;
        n = 0;
        while (host_ack && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (host_ack) begin
            $display("host_ack stayed high after host_req fell");
            errors++;
        end
        mem_model[addr] = data;
    endtask

    // writes the five words of one section, b0 first.
    task automatic set_section(input int k, input int b0, input int b1, input int b2,
                               input int a1, input int a2);
        int vals [5];
        vals = '{b0, b1, b2, a1, a2};
        for (int i = 0; i < 5; i++) begin
            host_write(filter_pkg::coef_addr_t'(k * filter_pkg::SECTION_STRIDE + i),
                       filter_pkg::coef_t'(vals[i]));
        end
    endtask

    task automatic do_reload();
        int n;
        @(negedge clk);
        reload = 1'b1;
        @(negedge clk);
        reload = 1'b0;
        if (!busy) begin
            $display("busy did not rise after a reload pulse");
            errors++;
        end
        n = 0;
        while (busy && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("reload never finished, busy is still high");
            errors++;
        end
    endtask

    // the model picks up the new set once the DUT reports it active.
    task automatic apply_reload();
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 5; i++) begin
                act[k][i] = mem_model[k * 8 + i];
            end
        end
    endtask

    task automatic send_sample(input string name, input filter_pkg::sample_t x,
                               output filter_pkg::sample_t got);
        filter_pkg::sample_t exp_y;
        int n;
        exp_y = model_step(x);
        @(negedge clk);
        sample_in    = x;
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;  // one-cycle strobe.
        n = 1;
        while (!sample_out_valid && n < 12) begin
            @(negedge clk);
            n++;
        end
        got = sample_out;
        if (!sample_out_valid) begin
            $display("%s: no output appeared for input %0d", name, x);
            errors++;
        end else if (n != 4) begin
            $display("MISMATCH %s latency: expected 4, actual %0d", name, n);
            errors++;
        end
        if (sample_out_valid && got !== exp_y) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp_y, got);
            errors++;
        end
        @(negedge clk);
        if (sample_out_valid) begin
            $display("%s: sample_out_valid lasted more than one cycle", name);
            errors++;
        end
    endtask

    task automatic reset_state();
        filter_pkg::sample_t got;
        if (sample_out_valid || host_ack || busy) begin
            $display("reset_state: an output is high right after reset");
            errors++;
        end
        send_sample("reset_state", 16'sd12345, got);
        if (got !== 16'sd0) begin
            $display("MISMATCH reset_state: expected 0, actual %0d", got);
            errors++;
        end
    endtask

    task automatic passthrough();
        filter_pkg::sample_t x, got;
        set_section(0, 16384, 0, 0, 0, 0);  // b0 is exactly 1.0.
        set_section(1, 16384, 0, 0, 0, 0);
        do_reload();
        apply_reload();
        repeat (10) begin
            x = filter_pkg::sample_t'(lcg_next() >> 16);
            send_sample("passthrough", x, got);
            if (got !== x) begin
                $display("MISMATCH passthrough: expected %0d, actual %0d", x, got);
                errors++;
            end
        end
    endtask

    // feed-forward only with each b between -0.5 and 0.5.
    task automatic fir_random();
        filter_pkg::sample_t got;
        int c [6];
        for (int i = 0; i < 6; i++) begin
            c[i] = int'(lcg_next() >> 18) - 8192;
        end
        set_section(0, c[0], c[1], c[2], 0, 0);
        set_section(1, c[3], c[4], c[5], 0, 0);
        do_reload();
        apply_reload();
        repeat (50) send_sample("fir_random", filter_pkg::sample_t'(lcg_next() >> 16), got);
    endtask

    // double pole at 0.5 and a DC gain of four per section.
    task automatic iir_feedback();
        filter_pkg::sample_t got;
        set_section(0, 4096, 8192, 4096, -16384, 4096);
        set_section(1, 4096, 8192, 4096, -16384, 4096);
        do_reload();
        apply_reload();
        send_sample("iir_feedback", 16'sd8000, got);  // impulse.
        repeat (10) send_sample("iir_feedback", 16'sd0, got);
        repeat (15) send_sample("iir_feedback", 16'sd1000, got);  // step.
    endtask

    task automatic saturation();
        filter_pkg::sample_t got;
        set_section(0, 32767, 0, 0, 0, 0);  // gain just under 2.0.
        set_section(1, 32767, 0, 0, 0, 0);
        do_reload();
        apply_reload();
        send_sample("saturation", 16'sd32767, got);
        send_sample("saturation", filter_pkg::sample_t'(-32768), got);
        send_sample("saturation", 16'sd5000, got);
        send_sample("saturation", -16'sd20000, got);
    endtask

    // host writes to the spare words while both loaders fetch.
    task automatic reload_arbitration();
        filter_pkg::sample_t got;
        set_section(0, 8192, 4096, -2048, 0, 0);
        set_section(1, 12000, -3000, 1500, 0, 0);
        fork
            do_reload();
            send_sample("reload_arbitration", 16'sd1000, got);  // still uses the old set.
            begin
                for (int a = 5; a < 8; a++) begin
                    host_write(filter_pkg::coef_addr_t'(a), filter_pkg::coef_t'(lcg_next()));
                    host_write(filter_pkg::coef_addr_t'(a + 8), filter_pkg::coef_t'(lcg_next()));
                end
            end
        join
        apply_reload();
        repeat (8) send_sample("reload_arbitration", filter_pkg::sample_t'(lcg_next() >> 16), got);
    endtask

    initial begin
        reset        = 1'b1;
        host_req     = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        reload       = 1'b0;
        sample_in    = '0;
        sample_valid = 1'b0;
        errors       = 0;
        lcg_state    = 32'h87ac_25d4;
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 5; i++) begin
                act[k][i] = '0;  // the DUT starts with a zero set.
            end
            hx1[k] = '0;
            hx2[k] = '0;
            hy1[k] = '0;
            hy2[k] = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        reset_state();
        passthrough();
        fir_random();
        iir_feedback();
        saturation();
        reload_arbitration();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== biquad_cascade.f ====
filter_pkg.sv
coef_bank.sv
coef_arbiter.sv
biquad_section.sv
biquad_cascade.sv
tb_biquad_cascade.sv

// ==== Bender.yml ====
package:
  name: biquad_cascade

sources:
  - filter_pkg.sv
  - coef_bank.sv
  - coef_arbiter.sv
  - biquad_section.sv
  - biquad_cascade.sv
  - target: test
    files:
      - tb_biquad_cascade.sv
